// ==== tb.f ====
src/backend_pkg.sv
src/decoder.sv
src/dispatch.sv
src/execute.sv
src/wb.sv
src/ctrl.sv
src/regs_file.sv
src/backend_top.sv
tests/backend_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f tb.f --top-module backend_tb -o backend_tb
./obj_dir/backend_tb

// ==== tests/backend_tb.sv ====
`default_nettype none

module backend_tb;

    localparam int RESET_CYCLES = 16;
    localparam int CNT_GAP = 5;
    localparam bus_nop = 32'h03400000;

    logic clk = 1'b0;
    logic rst_i;
    backend_pkg::bus32_t pc_i;
    backend_pkg::bus32_t inst_i;
    logic valid_i;
    backend_pkg::commit_t commit_o;
    backend_pkg::bus32_t new_pc_o;
    logic branch_flush_o;
    backend_pkg::branch_update_t update_info_o;
    logic [backend_pkg::PIPE_WIDTH-1:0] flush_o;

    // golden model state
    backend_pkg::bus32_t model [32];
    backend_pkg::commit_t exp_commits [$];
    logic exp_is_cnt [$];
    int exp_edge [$];
    backend_pkg::branch_update_t exp_updates [$];
    backend_pkg::bus32_t cnt_vals [$];
    backend_pkg::bus32_t next_pc;
    backend_pkg::bus32_t redirect_pc;
    int shadow;
    int issued;
    int cycle;
    integer seed;

    backend_top #(
        .PIPE_W    (backend_pkg::PIPE_WIDTH),
        .CNT_WIDTH (64)
    ) dut0 (
        .clk            (clk),
        .rst_i          (rst_i),
        .pc_i           (pc_i),
        .inst_i         (inst_i),
        .valid_i        (valid_i),
        .commit_o       (commit_o),
        .new_pc_o       (new_pc_o),
        .branch_flush_o (branch_flush_o),
        .update_info_o  (update_info_o),
        .flush_o        (flush_o)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic abort_run;
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic compare_word(input backend_pkg::bus32_t got, input backend_pkg::bus32_t want,
                                input string what);
        if (got !== want) begin
            $display("FAILED at time %0t: %s got %h expected %h", $time, what, got, want);
            abort_run();
        end
    endtask

    task automatic compare_commit(input backend_pkg::commit_t got,
                                  input backend_pkg::commit_t want);
        logic bad;
        bad = (got.valid !== want.valid) || (got.pc !== want.pc) || (got.we !== want.we);
        // rd and data only mean something for a register write
        if (want.we) begin
            bad = bad || (got.rd !== want.rd) || (got.data !== want.data);
        end
        if (bad) begin
            $display("FAILED at time %0t: commit got pc %h we %b rd %0d data %h",
                     $time, got.pc, got.we, got.rd, got.data);
            $display("    expected pc %h we %b rd %0d data %h",
                     want.pc, want.we, want.rd, want.data);
            abort_run();
        end
    endtask

    task automatic compare_update(input backend_pkg::branch_update_t got,
                                  input backend_pkg::branch_update_t want);
        if (got !== want) begin
            $display("FAILED at time %0t: update got pc %h taken %b target %h",
                     $time, got.pc, got.taken, got.target);
            $display("    expected pc %h taken %b target %h", want.pc, want.taken, want.target);
            abort_run();
        end
    endtask

    task automatic check_outputs;
        backend_pkg::commit_t want;
        backend_pkg::branch_update_t upd;
        int due;
        if (update_info_o.valid && exp_updates.size() == 0) begin
            $display("branch update seen at %0t with no branch in flight", $time);
            abort_run();
        end else if (update_info_o.valid) begin
            upd = exp_updates.pop_front();
            compare_update(update_info_o, upd);
            compare_word(backend_pkg::bus32_t'(branch_flush_o),
                         backend_pkg::bus32_t'(upd.taken), "branch flush");
            compare_word(backend_pkg::bus32_t'(flush_o),
                         upd.taken ? 32'd3 : 32'd0, "flush vector");
            if (upd.taken) begin
                compare_word(new_pc_o, upd.target, "new pc");
            end
        end else begin
            compare_word(backend_pkg::bus32_t'(flush_o), 32'd0, "flush vector without branch");
        end
        if (commit_o.valid && exp_commits.size() == 0) begin
            $display("instruction retired at %0t with nothing left to retire", $time);
            abort_run();
        end else if (commit_o.valid) begin
            want = exp_commits.pop_front();
            due = exp_edge.pop_front();
            if (exp_is_cnt.pop_front()) begin
                // counter value is checked by its distance to the other read
                cnt_vals.push_back(commit_o.data);
                want.data = commit_o.data;
            end
            compare_word(backend_pkg::bus32_t'(cycle), backend_pkg::bus32_t'(due),
                         "commit edge");
            compare_commit(commit_o, want);
        end
    endtask

    always @(negedge clk) begin
        check_outputs();
    end

    initial begin
        forever begin
            @(negedge clk);
            if (cycle > RESET_CYCLES + issued + 40) begin
                $display("timeout at %0t: pipeline stopped retiring", $time);
                abort_run();
            end
        end
    end

    task automatic issue(input backend_pkg::bus32_t inst, input logic we,
                         input backend_pkg::reg_addr_t rd, input backend_pkg::bus32_t data,
                         input logic is_cnt);
        backend_pkg::commit_t want;
        @(posedge clk);
        pc_i <= next_pc;
        inst_i <= inst;
        valid_i <= 1'b1;
        issued++;
        if (shadow > 0) begin
            // offered behind a taken branch and never retires
            shadow--;
            next_pc = (shadow == 0) ? redirect_pc : next_pc + 32'd4;
        end else begin
            want.valid = 1'b1;
            want.pc = next_pc;
            want.we = we;
            want.rd = rd;
            want.data = data;
            exp_commits.push_back(want);
            exp_is_cnt.push_back(is_cnt);
            // cycle still holds the count before this edge
            exp_edge.push_back(cycle + 5);
            if (we && rd != 5'd0) begin
                model[rd] = data;
            end
            next_pc = next_pc + 32'd4;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            valid_i <= 1'b0;
            issued++;
        end
    endtask

    task automatic drain;
        @(posedge clk);
        valid_i <= 1'b0;
        while (exp_commits.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic nop;
        issue(bus_nop, 1'b0, 5'd0, 32'd0, 1'b0);
    endtask

    task automatic reg_op(input backend_pkg::alu_op_t op, input backend_pkg::reg_addr_t rd,
                          input backend_pkg::reg_addr_t rj, input backend_pkg::reg_addr_t rk);
        backend_pkg::bus32_t res;
        logic [16:0] opc;
        case (op)
            backend_pkg::ALU_SUB: begin
                res = model[rj] - model[rk];
                opc = 17'h00022;
            end
            backend_pkg::ALU_AND: begin
                res = model[rj] & model[rk];
                opc = 17'h00029;
            end
            backend_pkg::ALU_OR: begin
                res = model[rj] | model[rk];
                opc = 17'h0002a;
            end
            backend_pkg::ALU_XOR: begin
                res = model[rj] ^ model[rk];
                opc = 17'h0002b;
            end
            default: begin
                res = model[rj] + model[rk];
                opc = 17'h00020;
            end
        endcase
        issue({opc, rk, rj, rd}, 1'b1, rd, res, 1'b0);
    endtask

    task automatic add_imm(input backend_pkg::reg_addr_t rd, input backend_pkg::reg_addr_t rj,
                           input logic [11:0] si12);
        issue({10'h00a, si12, rj, rd}, 1'b1, rd, model[rj] + {{20{si12[11]}}, si12}, 1'b0);
    endtask

    task automatic load_upper(input backend_pkg::reg_addr_t rd, input logic [19:0] si20);
        issue({7'h0a, si20, rd}, 1'b1, rd, {si20, 12'h000}, 1'b0);
    endtask

    task automatic read_counter;
        issue({22'h000018, 5'd0, 5'd0}, 1'b1, 5'd0, 32'd0, 1'b1);
    endtask

    task automatic branch(input backend_pkg::alu_op_t op, input backend_pkg::reg_addr_t rj,
                          input backend_pkg::reg_addr_t rd, input logic [25:0] offs);
        backend_pkg::branch_update_t upd;
        backend_pkg::bus32_t inst;
        upd.valid = 1'b1;
        upd.pc = next_pc;
        upd.target = next_pc + {{14{offs[15]}}, offs[15:0], 2'b00};
        case (op)
            backend_pkg::ALU_BEQ: begin
                upd.taken = (model[rj] == model[rd]);
                inst = {6'h16, offs[15:0], rj, rd};
            end
            backend_pkg::ALU_BNE: begin
                upd.taken = (model[rj] != model[rd]);
                inst = {6'h17, offs[15:0], rj, rd};
            end
            default: begin
                upd.taken = 1'b1;
                upd.target = next_pc + {{4{offs[25]}}, offs, 2'b00};
                inst = {6'h14, offs[15:0], offs[25:16]};
            end
        endcase
        exp_updates.push_back(upd);
        issue(inst, 1'b0, 5'd0, 32'd0, 1'b0);
        if (upd.taken) begin
            shadow = 2;
            redirect_pc = upd.target;
        end
    endtask

    task automatic test_reset;
        repeat (RESET_CYCLES - 1) begin
            @(negedge clk);
            compare_word(backend_pkg::bus32_t'(commit_o.valid), 32'd0, "commit valid in reset");
            compare_word(backend_pkg::bus32_t'(flush_o), 32'd0, "flush vector in reset");
        end
        @(posedge clk);
        rst_i <= 1'b0;
        repeat (4) begin
            @(negedge clk);
            compare_word(backend_pkg::bus32_t'(commit_o.valid), 32'd0, "commit valid when idle");
            compare_word(backend_pkg::bus32_t'(branch_flush_o), 32'd0, "branch flush when idle");
        end
    endtask

    task automatic test_alu;
        backend_pkg::bus32_t v;
        for (int i = 1; i <= 16; i++) begin
            v = $random(seed);
            load_upper(backend_pkg::reg_addr_t'(i), v[19:0]);
            add_imm(backend_pkg::reg_addr_t'(i), backend_pkg::reg_addr_t'(i), v[31:20]);
        end
        for (int i = 0; i < 15; i++) begin
            v = $random(seed);
            reg_op(backend_pkg::alu_op_t'(i % 5), backend_pkg::reg_addr_t'(9 + v[2:0]),
                   backend_pkg::reg_addr_t'(1 + v[6:3]), backend_pkg::reg_addr_t'(1 + v[10:7]));
        end
    endtask

    task automatic test_forward;
        backend_pkg::bus32_t v;
        for (int d = 1; d <= 3; d++) begin
            v = $random(seed);
            add_imm(5'd10, 5'd1, v[11:0]);
            repeat (d - 1) nop();
            reg_op(backend_pkg::ALU_SUB, 5'd11, 5'd10, 5'd2);
            // r0 result must not be forwarded
            add_imm(5'd0, 5'd11, v[23:12]);
            repeat (d - 1) nop();
            reg_op(backend_pkg::ALU_ADD, 5'd12, 5'd0, 5'd11);
        end
        repeat (3) reg_op(backend_pkg::ALU_ADD, 5'd13, 5'd13, 5'd13);
    endtask

    task automatic test_branch_taken;
        for (int i = 0; i < 3; i++) begin
            case (i)
                0: branch(backend_pkg::ALU_BEQ, 5'd1, 5'd1, 26'h0000010);
                1: branch(backend_pkg::ALU_BNE, 5'd1, 5'd2, 26'h3fffff8);
                default: branch(backend_pkg::ALU_B, 5'd0, 5'd0, 26'h0010040);
            endcase
            // two shadow writes, then the first instruction at the target
            add_imm(5'd3, 5'd3, 12'h7ff);
            add_imm(5'd4, 5'd3, 12'h001);
            reg_op(backend_pkg::ALU_ADD, 5'd5, 5'd3, 5'd4);
        end
    endtask

    task automatic test_branch_not_taken;
        load_upper(5'd7, 20'h12345);
        load_upper(5'd8, 20'h54321);
        branch(backend_pkg::ALU_BEQ, 5'd7, 5'd8, 26'h0000020);
        add_imm(5'd7, 5'd7, 12'h010);
        branch(backend_pkg::ALU_BNE, 5'd6, 5'd6, 26'h0000020);
        add_imm(5'd8, 5'd7, 12'h020);
        reg_op(backend_pkg::ALU_XOR, 5'd9, 5'd7, 5'd8);
    endtask

    task automatic test_counter;
        cnt_vals.delete();
        read_counter();
        idle(CNT_GAP - 1);
        read_counter();
        drain();
        compare_word(cnt_vals[1] - cnt_vals[0], backend_pkg::bus32_t'(CNT_GAP),
                     "counter distance");
    endtask

    initial begin
        seed = 136;
        rst_i = 1'b1;
        pc_i = 32'd0;
        inst_i = 32'd0;
        valid_i = 1'b0;
        cycle = 0;
        issued = 0;
        shadow = 0;
        next_pc = 32'h1c000000;
        redirect_pc = 32'd0;
        for (int i = 0; i < 32; i++) begin
            model[i] = 32'd0;
        end
        test_reset();
        test_alu();
        test_forward();
        test_branch_taken();
        test_branch_not_taken();
        test_counter();
        drain();
        // a stray commit would show up here
        repeat (4) @(negedge clk);
        if (exp_updates.size() != 0) begin
            $display("branch updates expected but never seen");
            abort_run();
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== src/backend_top.sv ====
`default_nettype none

module backend_top #(
    parameter int PIPE_W = backend_pkg::PIPE_WIDTH,
    parameter int CNT_WIDTH = 64
) (
    input  wire logic                     clk,
    input  wire logic                     rst_i,

    // from instruction buffer
    input  wire backend_pkg::bus32_t      pc_i,
    input  wire backend_pkg::bus32_t      inst_i,
    input  wire logic                     valid_i,

    output backend_pkg::commit_t          commit_o,
    output backend_pkg::bus32_t           new_pc_o,
    output logic                          branch_flush_o,
    output backend_pkg::branch_update_t   update_info_o,
    output logic [PIPE_W-1:0]             flush_o
);

    backend_pkg::id_dispatch_t dispatch_rec;
    backend_pkg::dispatch_ex_t ex_rec;
    backend_pkg::commit_t mem_rec;
    backend_pkg::pipeline_push_forward_t ex_pf;
    backend_pkg::pipeline_push_forward_t wb_pf;
    backend_pkg::bus32_t branch_target;

    backend_pkg::reg_addr_t [1:0] rf_raddr;
    backend_pkg::bus32_t [1:0] rf_rdata;
    logic rf_we;
    backend_pkg::reg_addr_t rf_waddr;
    backend_pkg::bus32_t rf_wdata;

    decoder u_decoder (
        .clk        (clk),
        .rst_i      (rst_i),
        .flush_i    (flush_o[0]),
        .pc_i       (pc_i),
        .inst_i     (inst_i),
        .valid_i    (valid_i),
        .dispatch_o (dispatch_rec)
    );

    dispatch u_dispatch (
        .clk        (clk),
        .rst_i      (rst_i),
        .flush_i    (flush_o[1]),
        .dispatch_i (dispatch_rec),
        .ex_pf_i    (ex_pf),
        .wb_pf_i    (wb_pf),
        .rdata_i    (rf_rdata),
        .raddr_o    (rf_raddr),
        .ex_o       (ex_rec)
    );

    execute #(
        .CNT_WIDTH (CNT_WIDTH)
    ) u_execute (
        .clk             (clk),
        .rst_i           (rst_i),
        .ex_i            (ex_rec),
        .mem_o           (mem_rec),
        .ex_pf_o         (ex_pf),
        .branch_flush_o  (branch_flush_o),
        .branch_target_o (branch_target),
        .update_info_o   (update_info_o)
    );

    wb u_wb (
        .clk      (clk),
        .rst_i    (rst_i),
        .wb_i     (mem_rec),
        .commit_o (commit_o),
        .wb_pf_o  (wb_pf)
    );

    ctrl #(
        .PIPE_W (PIPE_W)
    ) u_ctrl (
        .branch_flush_i  (branch_flush_o),
        .branch_target_i (branch_target),
        .commit_i        (commit_o),
        .flush_o         (flush_o),
        .new_pc_o        (new_pc_o),
        .we_o            (rf_we),
        .waddr_o         (rf_waddr),
        .wdata_o         (rf_wdata)
    );

    regs_file u_regs_file (
        .clk     (clk),
        .we_i    (rf_we),
        .waddr_i (rf_waddr),
        .wdata_i (rf_wdata),
        .raddr_i (rf_raddr),
        .rdata_o (rf_rdata)
    );

endmodule

`default_nettype wire

// ==== src/regs_file.sv ====
`default_nettype none

module regs_file (
    input  wire logic                          clk,
    input  wire logic                          we_i,
    input  wire backend_pkg::reg_addr_t        waddr_i,
    input  wire backend_pkg::bus32_t           wdata_i,
    input  wire backend_pkg::reg_addr_t [1:0]  raddr_i,
    output backend_pkg::bus32_t [1:0]          rdata_o
);

    backend_pkg::bus32_t regs [32];

    always_ff @(posedge clk) begin
        if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    for (genvar i = 0; i < 2; i++) begin : g_rd
        always_comb begin
            if (raddr_i[i] == '0) begin
                rdata_o[i] = '0;
            end else if (we_i && waddr_i == raddr_i[i]) begin
                // same-cycle write passes through
                rdata_o[i] = wdata_i;
            end else begin
                rdata_o[i] = regs[raddr_i[i]];
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/ctrl.sv ====
`default_nettype none

module ctrl #(
    parameter int PIPE_W = 3
) (
    input  wire logic                  branch_flush_i,
    input  wire backend_pkg::bus32_t   branch_target_i,
    input  wire backend_pkg::commit_t  commit_i,
    output logic [PIPE_W-1:0]          flush_o,
    output backend_pkg::bus32_t        new_pc_o,
    output logic                       we_o,
    output backend_pkg::reg_addr_t     waddr_o,
    output backend_pkg::bus32_t        wdata_o
);

    // kill the input slot and the decoder register, upper bits stay reserved
    assign flush_o = (branch_flush_i) ? {{(PIPE_W-2){1'b0}}, 2'b11} : '0;
    assign new_pc_o = branch_target_i;

    assign we_o = commit_i.valid && commit_i.we;
    assign waddr_o = commit_i.rd;
    assign wdata_o = commit_i.data;

endmodule

`default_nettype wire

// ==== src/wb.sv ====
`default_nettype none

module wb (
    input  wire logic                    clk,
    input  wire logic                    rst_i,
    input  wire backend_pkg::commit_t    wb_i,
    output backend_pkg::commit_t         commit_o,
    output backend_pkg::pipeline_push_forward_t wb_pf_o
);

    // view of the registered execute result, two instructions back
    assign wb_pf_o.valid = wb_i.valid;
    assign wb_pf_o.we = wb_i.we;
    assign wb_pf_o.rd = wb_i.rd;
    assign wb_pf_o.data = wb_i.data;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            commit_o.valid <= 1'b0;
        end else begin
            commit_o.valid <= wb_i.valid;
        end
        commit_o.pc <= wb_i.pc;
        commit_o.we <= wb_i.we;
        commit_o.rd <= wb_i.rd;
        commit_o.data <= wb_i.data;
    end

endmodule

`default_nettype wire

// ==== src/execute.sv ====
`default_nettype none

module execute #(
    parameter int CNT_WIDTH = 64
) (
    input  wire logic                         clk,
    input  wire logic                         rst_i,
    input  wire backend_pkg::dispatch_ex_t    ex_i,
    output backend_pkg::commit_t              mem_o,
    output backend_pkg::pipeline_push_forward_t ex_pf_o,
    output logic                              branch_flush_o,
    output backend_pkg::bus32_t               branch_target_o,
    output backend_pkg::branch_update_t       update_info_o
);

    logic [CNT_WIDTH-1:0] stable_cnt;
    backend_pkg::bus32_t result;
    logic is_branch;
    logic taken;

    // free running, read by rdcntvl.w
    always_ff @(posedge clk) begin
        if (rst_i) begin
            stable_cnt <= '0;
        end else begin
            stable_cnt <= stable_cnt + 1'b1;
        end
    end

    always_comb begin
        case (ex_i.alu_op)
            backend_pkg::ALU_ADD:   result = ex_i.src1 + ex_i.src2;
            backend_pkg::ALU_SUB:   result = ex_i.src1 - ex_i.src2;
            backend_pkg::ALU_AND:   result = ex_i.src1 & ex_i.src2;
            backend_pkg::ALU_OR:    result = ex_i.src1 | ex_i.src2;
            backend_pkg::ALU_XOR:   result = ex_i.src1 ^ ex_i.src2;
            backend_pkg::ALU_LUI:   result = ex_i.imm;
            backend_pkg::ALU_RDCNT: result = stable_cnt[31:0];
            default:                result = '0;
        endcase
    end

    always_comb begin
        is_branch = 1'b1;
        case (ex_i.alu_op)
            backend_pkg::ALU_BEQ: taken = (ex_i.src1 == ex_i.src2);
            backend_pkg::ALU_BNE: taken = (ex_i.src1 != ex_i.src2);
            backend_pkg::ALU_B:   taken = 1'b1;
            default: begin
                is_branch = 1'b0;
                taken = 1'b0;
            end
        endcase
    end

    assign branch_target_o = ex_i.pc + ex_i.imm;
    assign branch_flush_o = ex_i.valid && taken;

    assign update_info_o.valid = ex_i.valid && is_branch;
    assign update_info_o.pc = ex_i.pc;
    assign update_info_o.taken = taken;
    assign update_info_o.target = branch_target_o;

    // distance-1 bypass straight from the ALU
    assign ex_pf_o.valid = ex_i.valid;
    assign ex_pf_o.we = ex_i.we;
    assign ex_pf_o.rd = ex_i.rd;
    assign ex_pf_o.data = result;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mem_o.valid <= 1'b0;
        end else begin
            mem_o.valid <= ex_i.valid;
        end
        mem_o.pc <= ex_i.pc;
        mem_o.we <= ex_i.we;
        mem_o.rd <= ex_i.rd;
        mem_o.data <= result;
    end

endmodule

`default_nettype wire

// ==== src/dispatch.sv ====
`default_nettype none

module dispatch (
    input  wire logic                                clk,
    input  wire logic                                rst_i,
    input  wire logic                                flush_i,
    input  wire backend_pkg::id_dispatch_t           dispatch_i,
    input  wire backend_pkg::pipeline_push_forward_t ex_pf_i,
    input  wire backend_pkg::pipeline_push_forward_t wb_pf_i,
    input  wire backend_pkg::bus32_t [1:0]           rdata_i,
    output backend_pkg::reg_addr_t [1:0]             raddr_o,
    output backend_pkg::dispatch_ex_t                ex_o
);

    backend_pkg::bus32_t op_a;
    backend_pkg::bus32_t op_b;

    function automatic logic fwd_hit(
        input backend_pkg::pipeline_push_forward_t pf,
        input backend_pkg::reg_addr_t idx
    );
        return pf.valid && pf.we && (pf.rd != '0) && (pf.rd == idx);
    endfunction

    // youngest producer wins
    function automatic backend_pkg::bus32_t pick(
        input backend_pkg::reg_addr_t idx,
        input backend_pkg::bus32_t rf_val,
        input backend_pkg::pipeline_push_forward_t ex_pf,
        input backend_pkg::pipeline_push_forward_t wb_pf
    );
        if (fwd_hit(ex_pf, idx)) begin
            return ex_pf.data;
        end else if (fwd_hit(wb_pf, idx)) begin
            return wb_pf.data;
        end
        return rf_val;
    endfunction

    assign raddr_o[0] = dispatch_i.rj;
    assign raddr_o[1] = dispatch_i.rk;

    assign op_a = pick(dispatch_i.rj, rdata_i[0], ex_pf_i, wb_pf_i);
    assign op_b = pick(dispatch_i.rk, rdata_i[1], ex_pf_i, wb_pf_i);

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            ex_o.valid <= 1'b0;
        end else begin
            ex_o.valid <= dispatch_i.valid;
        end
        ex_o.pc <= dispatch_i.pc;
        ex_o.alu_op <= dispatch_i.alu_op;
        ex_o.rd <= dispatch_i.rd;
        ex_o.we <= dispatch_i.we;
        ex_o.src1 <= op_a;
        ex_o.src2 <= (dispatch_i.src2_is_imm) ? dispatch_i.imm : op_b;
        ex_o.imm <= dispatch_i.imm;
    end

endmodule

`default_nettype wire

// ==== src/decoder.sv ====
`default_nettype none

module decoder (
    input  wire logic                      clk,
    input  wire logic                      rst_i,
    input  wire logic                      flush_i,
    input  wire backend_pkg::bus32_t       pc_i,
    input  wire backend_pkg::bus32_t       inst_i,
    input  wire logic                      valid_i,
    output backend_pkg::id_dispatch_t      dispatch_o
);

    // opcode fields, 3R ops are matched on inst[31:15]
    localparam logic [16:0] OP_ADD_W   = 17'h00020;
    localparam logic [16:0] OP_SUB_W   = 17'h00022;
    localparam logic [16:0] OP_AND     = 17'h00029;
    localparam logic [16:0] OP_OR      = 17'h0002a;
    localparam logic [16:0] OP_XOR     = 17'h0002b;
    localparam logic [9:0]  OP_ADDI_W  = 10'h00a;
    localparam logic [6:0]  OP_LU12I_W = 7'h0a;
    localparam logic [5:0]  OP_BEQ     = 6'h16;
    localparam logic [5:0]  OP_BNE     = 6'h17;
    localparam logic [5:0]  OP_B       = 6'h14;
    localparam logic [21:0] OP_RDCNT   = 22'h000018;

    backend_pkg::id_dispatch_t dec;

    always_comb begin
        dec.valid = valid_i;
        dec.pc = pc_i;
        dec.alu_op = backend_pkg::ALU_NOP;
        dec.rj = inst_i[9:5];
        dec.rk = inst_i[14:10];
        dec.rd = inst_i[4:0];
        dec.we = 1'b0;
        dec.imm = {{20{inst_i[21]}}, inst_i[21:10]};
        dec.src2_is_imm = 1'b0;

        if (inst_i[31:15] == OP_ADD_W) begin
            dec.alu_op = backend_pkg::ALU_ADD;
            dec.we = 1'b1;
        end else if (inst_i[31:15] == OP_SUB_W) begin
            dec.alu_op = backend_pkg::ALU_SUB;
            dec.we = 1'b1;
        end else if (inst_i[31:15] == OP_AND) begin
            dec.alu_op = backend_pkg::ALU_AND;
            dec.we = 1'b1;
        end else if (inst_i[31:15] == OP_OR) begin
            dec.alu_op = backend_pkg::ALU_OR;
            dec.we = 1'b1;
        end else if (inst_i[31:15] == OP_XOR) begin
            dec.alu_op = backend_pkg::ALU_XOR;
            dec.we = 1'b1;
        end else if (inst_i[31:22] == OP_ADDI_W) begin
            dec.alu_op = backend_pkg::ALU_ADD;
            dec.we = 1'b1;
            dec.src2_is_imm = 1'b1;
        end else if (inst_i[31:25] == OP_LU12I_W) begin
            dec.alu_op = backend_pkg::ALU_LUI;
            dec.we = 1'b1;
            dec.imm = {inst_i[24:5], 12'b0};
            dec.src2_is_imm = 1'b1;
        end else if (inst_i[31:26] == OP_BEQ || inst_i[31:26] == OP_BNE) begin
            dec.alu_op = (inst_i[26]) ? backend_pkg::ALU_BNE : backend_pkg::ALU_BEQ;
            // second compare operand lives in the rd field
            dec.rk = inst_i[4:0];
            dec.imm = {{14{inst_i[25]}}, inst_i[25:10], 2'b00};
        end else if (inst_i[31:26] == OP_B) begin
            dec.alu_op = backend_pkg::ALU_B;
            dec.imm = {{4{inst_i[9]}}, inst_i[9:0], inst_i[25:10], 2'b00};
        end else if (inst_i[31:10] == OP_RDCNT && inst_i[9:5] == 5'd0) begin
            dec.alu_op = backend_pkg::ALU_RDCNT;
            dec.we = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            dispatch_o.valid <= 1'b0;
        end else begin
            dispatch_o.valid <= dec.valid;
        end
        dispatch_o.pc <= dec.pc;
        dispatch_o.alu_op <= dec.alu_op;
        dispatch_o.rj <= dec.rj;
        dispatch_o.rk <= dec.rk;
        dispatch_o.rd <= dec.rd;
        dispatch_o.we <= dec.we;
        dispatch_o.imm <= dec.imm;
        dispatch_o.src2_is_imm <= dec.src2_is_imm;
    end

endmodule

`default_nettype wire

// ==== src/backend_pkg.sv ====
`default_nettype none

package backend_pkg;

    localparam int PIPE_WIDTH = 3;

    typedef logic [31:0] bus32_t;
    typedef logic [4:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_LUI,
        ALU_BEQ,
        ALU_BNE,
        ALU_B,
        ALU_RDCNT,
        ALU_NOP
    } alu_op_t;

    typedef struct packed {
        logic valid;
        bus32_t pc;
        alu_op_t alu_op;
        reg_addr_t rj;
        reg_addr_t rk;
        reg_addr_t rd;
        logic we;
        bus32_t imm;
        logic src2_is_imm;
    } id_dispatch_t;

    typedef struct packed {
        logic valid;
        bus32_t pc;
        alu_op_t alu_op;
        reg_addr_t rd;
        logic we;
        bus32_t src1;
        bus32_t src2;
        bus32_t imm;
    } dispatch_ex_t;

    typedef struct packed {
        logic valid;
        logic we;
        reg_addr_t rd;
        bus32_t data;
    } pipeline_push_forward_t;

    typedef struct packed {
        logic valid;
        bus32_t pc;
        logic we;
        reg_addr_t rd;
        bus32_t data;
    } commit_t;

    typedef struct packed {
        logic valid;
        bus32_t pc;
        logic taken;
        bus32_t target;
    } branch_update_t;

endpackage

`default_nettype wire
